/* Makefile */
TOP := tb_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f verilog.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

/* src/mont_decode.sv */
`default_nettype none

module mont_decode (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire mont_pkg::mont_req_t  req,
    input  wire logic                 req_valid,
    output logic                      req_credit,
    output mont_pkg::mont_op_t        op,
    output logic                      start,
    input  wire mont_pkg::mont_word_t product,
    input  wire logic                 done,
    input  wire logic                 slot_ready,
    output logic                      push,
    output mont_pkg::mont_word_t      push_data
);
    import mont_pkg::*;

    mont_req_t  slot;       // single request slot
    logic       slot_full;
    mont_req_t  work;       // request of the running job
    mont_word_t r1;         // x*R, later x*y*R
    mont_word_t r2;         // y*R
    mont_pass_e pass;
    logic       running;
    logic       take;

    // a result still being pushed is not yet counted by the fifo
    assign take = slot_full && !running && !push && slot_ready;

    // ------------------------------------------------------------------------
    // operand select per pass
    // ------------------------------------------------------------------------
    always_comb begin
        op.m = work.m;
        unique case (pass)
            pass_x_rou: begin
                op.a = work.x;
                op.b = work.rou;
            end
            pass_y_rou: begin
                op.a = work.y;
                op.b = work.rou;
            end
            pass_mult: begin
                op.a = r1;
                op.b = r2;
            end
            pass_out: begin
                op.a = r1;
                op.b = mont_word_t'(1);     // multiply by one strips R
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // sequencer control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_full  <= 1'b0;
            req_credit <= 1'b0;
            running    <= 1'b0;
            pass       <= pass_x_rou;
            start      <= 1'b0;
            push       <= 1'b0;
        end else begin
            req_credit <= take;             // credit back once the slot drains
            start      <= 1'b0;
            push       <= 1'b0;
            if (take)
                slot_full <= 1'b0;
            if (req_valid)
                slot_full <= 1'b1;
            if (take) begin
                running <= 1'b1;
                pass    <= pass_x_rou;
                start   <= 1'b1;
            end else if (running && done) begin
                if (pass == pass_out) begin
                    running <= 1'b0;
                    push    <= 1'b1;
                end else begin
                    pass  <= mont_pass_e'(pass + 2'd1);
                    start <= 1'b1;          // dispatch next pass
                end
            end
        end
    end

    // slot, working copy and intermediate results
    always_ff @(posedge clk) begin
        if (req_valid)
            slot <= req;
        if (take)
            work <= slot;
        if (running && done) begin
            unique case (pass)
                pass_x_rou: r1        <= product;
                pass_y_rou: r2        <= product;
                pass_mult:  r1        <= product;   // engine already holds old r1
                pass_out:   push_data <= product;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/mont_execute.sv */
`default_nettype none

module mont_execute (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire mont_pkg::mont_op_t   op,
    input  wire logic                 start,
    output mont_pkg::mont_word_t      product,
    output logic                      done
);
    import mont_pkg::*;

    localparam int acc_w = operand_w + 2;           // holds acc + b + m below 4m
    localparam int cnt_w = $clog2(operand_w + 1);
    localparam logic [cnt_w-1:0] last_step = cnt_w'(operand_w);

    logic [acc_w-1:0] acc;
    logic [acc_w-1:0] acc_sub;
    mont_word_t       a_q;      // shifts right, bit 0 is the current bit
    mont_word_t       b_q;
    mont_word_t       m_q;
    logic [cnt_w-1:0] step_cnt;
    logic             busy;

    // one radix-2 step
    function automatic logic [acc_w-1:0] mont_step(
        input logic [acc_w-1:0] acc_in,
        input logic             a_bit,
        input mont_word_t       b,
        input mont_word_t       m
    );
        logic [acc_w-1:0] sum;
        sum = acc_in;
        if (a_bit)
            sum = sum + {2'b00, b};
        if (sum[0])
            sum = sum + {2'b00, m};     // make it even so the halving is exact
        return {1'b0, sum[acc_w-1:1]};
    endfunction

    assign acc_sub = acc - {2'b00, m_q};

    // ------------------------------------------------------------------------
    // step counter, bit 0 runs on the start edge
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                step_cnt <= cnt_w'(1);
            end else if (busy) begin
                if (step_cnt == last_step) begin
                    busy <= 1'b0;           // subtract cycle
                    done <= 1'b1;
                end else begin
                    step_cnt <= step_cnt + cnt_w'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= mont_step('0, op.a[0], op.b, op.m);
            a_q <= op.a >> 1;
            b_q <= op.b;
            m_q <= op.m;
        end else if (busy) begin
            if (step_cnt == last_step) begin
                // acc is below 2m here, one subtraction is enough
                product <= (acc >= {2'b00, m_q}) ? acc_sub[operand_w-1:0]
                                                 : acc[operand_w-1:0];
            end else begin
                acc <= mont_step(acc, a_q[0], b_q, m_q);
                a_q <= a_q >> 1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/mont_pkg.sv */
`default_nettype none

package mont_pkg;

    localparam int operand_w = 32;

    typedef logic [operand_w-1:0] mont_word_t;

    // one request as the sender presents it, x and y below m
    typedef struct packed {
        mont_word_t x;
        mont_word_t y;
        mont_word_t m;      // odd modulus
        mont_word_t rou;    // 2^(2*operand_w) mod m
    } mont_req_t;

    // operands of a single montgomery product
    typedef struct packed {
        mont_word_t a;
        mont_word_t b;
        mont_word_t m;
    } mont_op_t;

    typedef enum logic [1:0] {
        pass_x_rou = 2'd0,  // x into montgomery form
        pass_y_rou = 2'd1,  // y into montgomery form
        pass_mult  = 2'd2,  // product of the two
        pass_out   = 2'd3   // back to normal form
    } mont_pass_e;

endpackage

`default_nettype wire

/* src/mont_result.sv */
`default_nettype none

module mont_result #(
    parameter int fifo_depth     = 4,
    parameter int result_credits = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 push,
    input  wire mont_pkg::mont_word_t push_data,
    output logic                      slot_ready,
    output mont_pkg::mont_word_t      res,
    output logic                      res_valid,
    input  wire logic                 res_credit
);
    import mont_pkg::*;

    localparam int ptr_w  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w  = $clog2(fifo_depth + 1);
    localparam int cred_w = (result_credits > 0) ? $clog2(result_credits + 1) : 1;
    localparam logic [ptr_w-1:0]  last_ptr  = ptr_w'(fifo_depth - 1);
    localparam logic [cnt_w-1:0]  depth_cnt = cnt_w'(fifo_depth);

    mont_word_t        mem [fifo_depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  fill;        // entries queued
    logic [cred_w-1:0] credits;     // results the consumer can still take
    logic              pop;

    // wraps at any depth, not only powers of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == last_ptr) ? '0 : p + ptr_w'(1);
    endfunction

    assign pop        = (credits != '0) && (fill != '0);
    assign slot_ready = fill < depth_cnt;

    // ------------------------------------------------------------------------
    // pointers, fill level and credits
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            credits   <= cred_w'(result_credits);
            res_valid <= 1'b0;
        end else begin
            res_valid <= pop;
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   fill <= fill + cnt_w'(1);
                2'b01:   fill <= fill - cnt_w'(1);
                default: fill <= fill;
            endcase
            case ({res_credit, pop})
                2'b10:   credits <= credits + cred_w'(1);
                2'b01:   credits <= credits - cred_w'(1);
                default: credits <= credits;    // returned and spent together
            endcase
        end
    end

    // storage and output word
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
        if (pop)
            res <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

/* src/mont_top.sv */
`default_nettype none

module mont_top #(
    parameter int fifo_depth     = 4,
    parameter int result_credits = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire mont_pkg::mont_req_t  req,
    input  wire logic                 req_valid,
    output logic                      req_credit,
    output mont_pkg::mont_word_t      res,
    output logic                      res_valid,
    input  wire logic                 res_credit
);
    import mont_pkg::*;

    mont_op_t   op;
    logic       start;
    mont_word_t product;
    logic       done;
    logic       push;
    mont_word_t push_data;
    logic       slot_ready;

    mont_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_credit (req_credit),
        .op         (op),
        .start      (start),
        .product    (product),
        .done       (done),
        .slot_ready (slot_ready),
        .push       (push),
        .push_data  (push_data)
    );

    mont_execute u_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .op      (op),
        .start   (start),
        .product (product),
        .done    (done)
    );

    mont_result #(
        .fifo_depth     (fifo_depth),
        .result_credits (result_credits)
    ) u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_data  (push_data),
        .slot_ready (slot_ready),
        .res        (res),
        .res_valid  (res_valid),
        .res_credit (res_credit)
    );

endmodule

`default_nettype wire

/* tb/tb_checker.sv */
`default_nettype none

module tb_checker #(
    parameter int result_credits = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire mont_pkg::mont_req_t  req,
    input  wire logic                 req_valid,
    input  wire logic                 req_credit,
    input  wire mont_pkg::mont_word_t res,
    input  wire logic                 res_valid,
    input  wire logic                 res_credit,
    output int                        errors,
    output int                        results
);
    timeunit 1ns;
    timeprecision 1ps;
    import mont_pkg::*;

    mont_word_t expected_q[$];     // one entry per request, oldest first
    mont_word_t expected;
    int         requests;
    int         credit_pulses;     // req_credit pulses seen
    int         granted;           // output credits handed to the DUT so far

    // plain modular product, no montgomery form involved
    function automatic mont_word_t mod_mult(
        input mont_word_t x,
        input mont_word_t y,
        input mont_word_t m
    );
        logic [63:0] prod;
        prod = {32'b0, x} * {32'b0, y};
        return mont_word_t'(prod % {32'b0, m});
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            expected_q.delete();
            requests      = 0;
            credit_pulses = 0;
            granted       = result_credits;
            results       = 0;
            errors        = 0;
        end else begin
            // results first, a request on this edge cannot have produced one
            if (res_valid) begin
                results++;
                if (results > granted) begin
                    errors++;
                    $display("res_valid asserted without an output credit (%0d results, %0d credits)",
                             results, granted);
                end
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("result %0d arrived with no request outstanding", results);
                end else begin
                    expected = expected_q.pop_front();
                    if (res !== expected) begin
                        errors++;
                        $display("mismatch res: got 0x%08h, expected 0x%08h", res, expected);
                        $display("test %0d failed", results);
                    end else begin
                        $display("test %0d ok, res 0x%08h", results, res);
                    end
                end
            end
            if (req_valid) begin
                expected_q.push_back(mod_mult(req.x, req.y, req.m));
                requests++;
            end
            if (req_credit) begin
                credit_pulses++;
                if (credit_pulses > requests) begin
                    errors++;
                    $display("req_credit pulsed %0d times for only %0d requests",
                             credit_pulses, requests);
                end
            end
            if (res_credit)
                granted++;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_top.sv */
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import mont_pkg::*;

    localparam int     num_tests      = 200;
    localparam int     fifo_depth     = 4;
    localparam int     result_credits = 2;
    localparam int     clk_period     = 40;
    localparam longint timeout_ns     = longint'(num_tests) * 200 * clk_period;
    localparam int     hold_after     = 40;     // results before credits are withheld
    localparam int     hold_cycles    = 2000;   // long enough to fill fifo and slot

    logic       clk        = 1'b0;
    logic       rst_n      = 1'b0;
    mont_req_t  req        = '0;
    logic       req_valid  = 1'b0;
    logic       req_credit;
    mont_word_t res;
    logic       res_valid;
    logic       res_credit = 1'b0;
    int         errors;
    int         results;

    int         seed        = 97;
    int         gap_seed    = 97;       // own stream for the consumer
    logic       have_credit = 1'b1;     // sender starts with the slot credit
    int         pending;                // results whose credit is not yet returned
    int         received;
    int         hold_left;
    logic       held;

    mont_top #(
        .fifo_depth     (fifo_depth),
        .result_credits (result_credits)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_credit (req_credit),
        .res        (res),
        .res_valid  (res_valid),
        .res_credit (res_credit)
    );

    tb_checker #(
        .result_credits (result_credits)
    ) i_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_credit (req_credit),
        .res        (res),
        .res_valid  (res_valid),
        .res_credit (res_credit),
        .errors     (errors),
        .results    (results)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    function automatic mont_word_t random_word();
        return $random(seed);
    endfunction

    // odd and full width, so any random word mod m is a valid operand
    function automatic mont_word_t random_modulus();
        mont_word_t m;
        m     = random_word();
        m[31] = 1'b1;
        m[0]  = 1'b1;
        return m;
    endfunction

    // 2^64 mod m by doubling
    function automatic mont_word_t compute_rou(input mont_word_t m);
        logic [32:0] r;
        r = 33'd1;
        repeat (2 * operand_w) begin
            r = r << 1;
            if (r >= {1'b0, m})
                r = r - {1'b0, m};
        end
        return r[31:0];
    endfunction

    task automatic tick();
        @(posedge clk);
        if (req_credit)
            have_credit = 1'b1;
    endtask

    task automatic send_request(input mont_word_t x, input mont_word_t y, input mont_word_t m);
        mont_req_t r;
        r.x   = x;
        r.y   = y;
        r.m   = m;
        r.rou = compute_rou(m);
        while (!have_credit)
            tick();
        req         <= r;
        req_valid   <= 1'b1;
        have_credit = 1'b0;     // spent until req_credit comes back
        tick();
        req_valid   <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // consumer returns one credit per result after a random gap
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            pending   = 0;
            received  = 0;
            hold_left = 0;
            held      = 1'b0;
        end else begin
            if (res_valid) begin
                pending++;
                received++;
            end
            if (received == hold_after && !held) begin
                hold_left = hold_cycles;
                held      = 1'b1;
            end
            res_credit <= 1'b0;
            if (hold_left > 0) begin
                hold_left--;
            end else if (pending > 0 && ($random(gap_seed) & 7) == 0) begin
                res_credit <= 1'b1;
                pending--;
            end
        end
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        mont_word_t m;
        mont_word_t x;
        mont_word_t y;
        int         gap;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (10) tick();     // idle cycles where nothing may come out
        m = random_modulus();
        x = random_word() % m;
        y = random_word() % m;
        send_request(32'd0, y, m);
        send_request(x, 32'd0, m);
        send_request(32'd1, y, m);
        send_request(m - 32'd1, m - 32'd1, m);
        for (int i = 4; i < num_tests; i++) begin
            m   = random_modulus();
            x   = random_word() % m;
            y   = random_word() % m;
            send_request(x, y, m);
            gap = random_word() % 32'd4;
            repeat (gap) tick();
        end
        while (results < num_tests)
            @(negedge clk);
        repeat (20) @(negedge clk);     // room for a stray extra result
        $display("%0d of %0d results checked, %0d errors", results, num_tests, errors);
        if (errors == 0 && results == num_tests)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns with %0d of %0d results received",
                 timeout_ns, results, num_tests);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
src/mont_pkg.sv
src/mont_decode.sv
src/mont_execute.sv
src/mont_result.sv
src/mont_top.sv
tb/tb_checker.sv
tb/tb_top.sv
